//--- vlog.f
+incdir+source
source/psum_pkg.sv
source/psum_fifo.sv
source/glb_arbiter.sv
source/glb_sram.sv
source/ipsum_fifo_ctrl.sv
source/opsum_wb_ctrl.sv
source/psum_top.sv
verification/psum_clk_gen.sv
verification/psum_checker.sv
verification/psum_props.sv
verification/psum_tb.sv

//--- Bender.yml
package:
  name: psum_stage

sources:
  - include_dirs:
      - source
    files:
      - source/psum_pkg.sv
      - source/psum_fifo.sv
      - source/glb_arbiter.sv
      - source/glb_sram.sv
      - source/ipsum_fifo_ctrl.sv
      - source/opsum_wb_ctrl.sv
      - source/psum_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/psum_clk_gen.sv
      - verification/psum_checker.sv
      - verification/psum_props.sv
      - verification/psum_tb.sv

//--- verification/psum_tb.sv
`timescale 1ns/1ns
`include "psum_cfg.svh"

module psum_tb;
    import psum_pkg::*;

    localparam int NUM_ROWS    = 7;
    localparam int RESET_LIMIT = 20;   // cycles
    localparam int READY_LIMIT = 100;
    localparam int DONE_LIMIT  = 3000;

    typedef struct packed {
        logic      clear;   // pulse fifo_clear_i first
        logic      overlap; // write while the pop task runs
        logic [1:0] gate;   // bit 0 gates move, bit 1 gates mask
        logic [7:0] n_words;
        glb_addr_t wr_base;
        glb_addr_t rd_base;
        pop_num_t  pop_num;
    } test_row_t;

    logic      clk;
    logic      rst_n;
    logic      fifo_clear_i;
    logic      need_pop_i;
    pop_num_t  pop_num_i;
    glb_addr_t ipsum_base_i;
    logic      mask_i;
    logic      pe_array_move_i;
    logic      opsum_valid_i;
    glb_data_t opsum_data_i;
    glb_addr_t opsum_base_i;
    logic      opsum_ready_o;
    logic      pop_valid_o;
    psum_t     pop_data_o;
    logic      is_pop_state_o;
    logic      done_o;

    test_row_t   rows [NUM_ROWS];
    glb_data_t   glb_model [`GLB_WORDS]; // words written through the opsum port
    glb_addr_t   wr_ptr_model;
    int unsigned rd_cursor;              // half words read since the last clear
    logic [31:0] lcg_state;
    logic        aborted;

    psum_clk_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

    psum_top dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .fifo_clear_i    (fifo_clear_i),
        .need_pop_i      (need_pop_i),
        .pop_num_i       (pop_num_i),
        .ipsum_base_i    (ipsum_base_i),
        .mask_i          (mask_i),
        .pe_array_move_i (pe_array_move_i),
        .opsum_valid_i   (opsum_valid_i),
        .opsum_data_i    (opsum_data_i),
        .opsum_base_i    (opsum_base_i),
        .opsum_ready_o   (opsum_ready_o),
        .pop_valid_o     (pop_valid_o),
        .pop_data_o      (pop_data_o),
        .is_pop_state_o  (is_pop_state_o),
        .done_o          (done_o)
    );

    psum_checker chk0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .pop_valid_i    (pop_valid_o),
        .pop_data_i     (pop_data_o),
        .mask_i         (mask_i),
        .move_i         (pe_array_move_i),
        .is_pop_state_i (is_pop_state_o),
        .done_i         (done_o),
        .opsum_valid_i  (opsum_valid_i),
        .opsum_ready_i  (opsum_ready_o)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int word_index(input glb_addr_t addr);
        return (addr >> 2) % `GLB_WORDS;
    endfunction

    task automatic load_table();
        // clear, overlap, gate, words, wr_base, rd_base, pops
        rows[0] = '{1'b1, 1'b0, 2'd0, 8'd4, 16'h0000, 16'h0000, 32'd8};
        rows[1] = '{1'b1, 1'b0, 2'd0, 8'd12, 16'h0040, 16'h0040, 32'(3 * `PSUM_FIFO_DEPTH)};
        rows[2] = '{1'b1, 1'b0, 2'd1, 8'd8, 16'h0080, 16'h0080, 32'd8};
        rows[3] = '{1'b0, 1'b0, 2'd2, 8'd0, 16'h0080, 16'h0080, 32'd8}; // carries on
        rows[4] = '{1'b1, 1'b0, 2'd3, 8'd0, 16'h0080, 16'h0080, 32'd4}; // back to base
        rows[5] = '{1'b1, 1'b1, 2'd1, 8'd6, 16'h0100, 16'h0000, 32'd8};
        rows[6] = '{1'b1, 1'b0, 2'd0, 8'd0, 16'h0100, 16'h0100, 32'd12};
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        fifo_clear_i <= 1'b1;
        @(posedge clk);
        fifo_clear_i <= 1'b0;
        wr_ptr_model = '0;
        rd_cursor    = 0;
    endtask

    task automatic write_words(input test_row_t row);
        glb_data_t word;
        glb_addr_t addr;
        int        waited;
        @(posedge clk);
        opsum_base_i <= row.wr_base;
        for (int i = 0; i < int'(row.n_words); i++) begin
            waited = 0;
            @(posedge clk);
            while (!opsum_ready_o && waited < READY_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (!opsum_ready_o) begin
                chk0.note_failure("timeout: opsum_ready_o never came back");
                aborted = 1'b1;
                return;
            end
            word = next_rand();
            addr = row.wr_base + wr_ptr_model;
            opsum_valid_i <= 1'b1;
            opsum_data_i  <= word;
            glb_model[word_index(addr)] = word;
            wr_ptr_model = wr_ptr_model + 16'd4; // one word per accept
            @(posedge clk);
            opsum_valid_i <= 1'b0;
        end
    endtask

    // low half then high half of each word, zero-extended
    task automatic queue_expected(input test_row_t row);
        glb_addr_t addr;
        glb_data_t word;
        for (int k = 0; k < int'(row.pop_num); k++) begin
            addr = row.rd_base + glb_addr_t'(2 * (rd_cursor + k));
            word = glb_model[word_index(addr)];
            chk0.expect_value(addr[1] ? {16'd0, word[31:16]} : {16'd0, word[15:0]});
        end
        rd_cursor = rd_cursor + row.pop_num;
    endtask

    task automatic run_pop(input test_row_t row);
        logic [31:0] r;
        int          waited;
        @(posedge clk);
        ipsum_base_i <= row.rd_base;
        pop_num_i    <= row.pop_num;
        need_pop_i   <= 1'b1;
        @(posedge clk);
        need_pop_i <= 1'b0;
        waited = 0;
        do begin
            r = next_rand();
            pe_array_move_i <= row.gate[0] ? r[27] : 1'b1;
            mask_i          <= row.gate[1] ? r[29] : 1'b1;
            @(posedge clk);
            waited++;
        end while (!done_o && waited < DONE_LIMIT);
        pe_array_move_i <= 1'b0;
        mask_i          <= 1'b0;
        if (!done_o) begin
            chk0.note_failure("timeout: done_o did not rise after the pop task");
            aborted = 1'b1;
        end
    endtask

    initial begin
        int waited;
        fifo_clear_i    = 1'b0;
        need_pop_i      = 1'b0;
        pop_num_i       = '0;
        ipsum_base_i    = '0;
        mask_i          = 1'b0;
        pe_array_move_i = 1'b0;
        opsum_valid_i   = 1'b0;
        opsum_data_i    = '0;
        opsum_base_i    = '0;
        lcg_state       = 32'h681e_9340;
        aborted         = 1'b0;
        wr_ptr_model    = '0;
        rd_cursor       = 0;
        load_table();

        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            chk0.note_failure("timeout: reset was never released");
            aborted = 1'b1;
        end
        @(posedge clk);
        chk0.check_reset_state();
        chk0.end_test(0);

        for (int idx = 0; idx < NUM_ROWS && !aborted; idx++) begin
            if (rows[idx].clear)
                pulse_clear();
            if (rows[idx].overlap) begin
                // reads and writes hit different regions, so expectations are fixed now
                queue_expected(rows[idx]);
                fork
                    write_words(rows[idx]);
                    run_pop(rows[idx]);
                join
            end else begin
                write_words(rows[idx]);
                queue_expected(rows[idx]);
                run_pop(rows[idx]);
            end
            chk0.end_test(idx + 1);
        end

        repeat (5) @(posedge clk); // room for stray pops
        $display("tests run %0d, tests failed %0d, errors %0d",
                 chk0.test_cnt, chk0.fail_cnt, chk0.err_cnt);
        if (chk0.fail_cnt == 0 && chk0.err_cnt == 0 && !aborted)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- verification/psum_props.sv
`timescale 1ns/1ns

module psum_props (
    input logic clk,
    input logic rst_n,
    input logic gnt0_i,
    input logic gnt1_i,
    input logic req0_i,
    input logic req1_i,
    input logic push_i,
    input logic full_i,
    input logic pop_i,
    input logic pop_state_i
);

    one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(gnt0_i && gnt1_i))
        else $error("both glb grants high in one cycle");

    gnt0_has_req: assert property (@(posedge clk) disable iff (!rst_n) gnt0_i |-> req0_i)
        else $error("writeback granted without a request");

    gnt1_has_req: assert property (@(posedge clk) disable iff (!rst_n) gnt1_i |-> req1_i)
        else $error("fifo refill granted without a request");

    no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full_i)
        else $error("push into a full psum fifo");

    pop_in_state: assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> pop_state_i)
        else $error("pop outside the CAN_POP state");

endmodule

// arbiter side, fifo inputs tied off
bind glb_arbiter psum_props u_arb_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .gnt0_i      (gnt0_o),
    .gnt1_i      (gnt1_o),
    .req0_i      (req0_i),
    .req1_i      (req1_i),
    .push_i      (1'b0),
    .full_i      (1'b0),
    .pop_i       (1'b0),
    .pop_state_i (1'b0)
);

bind ipsum_fifo_ctrl psum_props u_ctrl_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .gnt0_i      (1'b0),
    .gnt1_i      (1'b0),
    .req0_i      (1'b0),
    .req1_i      (1'b0),
    .push_i      (fifo_push_o),
    .full_i      (fifo_full_i),
    .pop_i       (fifo_pop_o),
    .pop_state_i (is_pop_state_o)
);

//--- verification/psum_checker.sv
`timescale 1ns/1ns

module psum_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pop_valid_i,
    input  psum_pkg::psum_t pop_data_i,
    input  logic            mask_i,
    input  logic            move_i,
    input  logic            is_pop_state_i,
    input  logic            done_i,
    input  logic            opsum_valid_i,
    input  logic            opsum_ready_i
);
    import psum_pkg::*;

    psum_t exp_q [$];     // values the next pops must return
    psum_t head;
    int    err_cnt = 0;   // all errors so far
    int    test_errs = 0; // errors in the running test
    int    test_cnt = 0;
    int    fail_cnt = 0;
    int    pop_cnt = 0;
    logic  accepted_q = 1'b0; // a word was taken at the last edge

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (got !== exp) begin
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
            err_cnt++;
            test_errs++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s (t=%0t)", msg, $time);
        err_cnt++;
        test_errs++;
    endtask

    task automatic expect_value(input psum_t value);
        exp_q.push_back(value);
    endtask

    task automatic check_reset_state();
        check_value("done_o", 32'd1, 32'(done_i));
        check_value("pop_valid_o", 32'd0, 32'(pop_valid_i));
        check_value("is_pop_state_o", 32'd0, 32'(is_pop_state_i));
    endtask

    task automatic end_test(input int idx);
        if (exp_q.size() != 0) begin
            note_failure($sformatf("%0d expected pops never arrived", exp_q.size()));
            exp_q.delete();
        end
        check_value("done_o", 32'd1, 32'(done_i)); // task over means idle again
        test_cnt++;
        if (test_errs == 0) begin
            $display("test %0d passed, %0d pops checked", idx, pop_cnt);
        end else begin
            $display("test %0d failed with %0d errors", idx, test_errs);
            fail_cnt++;
        end
        test_errs = 0;
        pop_cnt   = 0;
    endtask

    always @(posedge clk) begin
        if (rst_n && pop_valid_i) begin
            // a stalled or masked PE array must hold the pop
            check_value("pop_valid_o", 32'(mask_i && move_i), 32'd1);
            if (exp_q.size() == 0) begin
                note_failure("pop seen while no value was expected");
            end else begin
                head = exp_q.pop_front();
                check_value("pop_data_o", head, pop_data_i);
                pop_cnt++;
            end
        end
    end

    // the held word blocks the writeback port until it is written
    always @(posedge clk) begin
        if (rst_n && accepted_q)
            check_value("opsum_ready_o", 32'd0, 32'(opsum_ready_i));
        accepted_q <= rst_n && opsum_valid_i && opsum_ready_i;
    end

endmodule

//--- verification/psum_clk_gen.sv
`timescale 1ns/1ns

module psum_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- source/psum_top.sv
`timescale 1ns/1ns

module psum_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fifo_clear_i,
    input  logic                need_pop_i,
    input  psum_pkg::pop_num_t  pop_num_i,
    input  psum_pkg::glb_addr_t ipsum_base_i,
    input  logic                mask_i,
    input  logic                pe_array_move_i,
    input  logic                opsum_valid_i,
    input  psum_pkg::glb_data_t opsum_data_i,
    input  psum_pkg::glb_addr_t opsum_base_i,
    output logic                opsum_ready_o,
    output logic                pop_valid_o,
    output psum_pkg::psum_t     pop_data_o,
    output logic                is_pop_state_o,
    output logic                done_o
);
    import psum_pkg::*;

    logic      opsum_req;
    logic      opsum_gnt;
    glb_req_t  opsum_pkt;
    logic      ipsum_read_req;
    logic      ipsum_gnt;
    glb_addr_t ipsum_read_addr;
    glb_req_t  ipsum_pkt;
    glb_req_t  glb_req;
    logic      glb_en;
    glb_data_t glb_rdata;
    logic      fifo_push;
    psum_t     fifo_push_data;
    logic      fifo_full;
    logic      fifo_empty;

    // reads never carry write data
    assign ipsum_pkt = '{we: 1'b0, addr: ipsum_read_addr, wdata: '0};

    opsum_wb_ctrl u_opsum_wb_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .fifo_clear_i  (fifo_clear_i),
        .opsum_valid_i (opsum_valid_i),
        .opsum_data_i  (opsum_data_i),
        .opsum_base_i  (opsum_base_i),
        .opsum_ready_o (opsum_ready_o),
        .wr_req_o      (opsum_req),
        .wr_pkt_o      (opsum_pkt),
        .wr_gnt_i      (opsum_gnt)
    );

    ipsum_fifo_ctrl u_ipsum_fifo_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .glb_busy_i       (opsum_gnt), // writeback holds the port
        .fifo_clear_i     (fifo_clear_i),
        .need_pop_i       (need_pop_i),
        .pop_num_i        (pop_num_i),
        .mask_i           (mask_i),
        .permit_push_i    (ipsum_gnt),
        .fifo_full_i      (fifo_full),
        .fifo_empty_i     (fifo_empty),
        .base_addr_i      (ipsum_base_i),
        .glb_rdata_i      (glb_rdata),
        .fifo_push_o      (fifo_push),
        .fifo_push_data_o (fifo_push_data),
        .fifo_pop_o       (pop_valid_o),
        .read_req_o       (ipsum_read_req),
        .read_addr_o      (ipsum_read_addr),
        .is_pop_state_o   (is_pop_state_o),
        .pe_array_move_i  (pe_array_move_i),
        .done_o           (done_o)
    );

    glb_arbiter u_glb_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .req0_i     (opsum_req),
        .req0_i_pkt (opsum_pkt),
        .req1_i     (ipsum_read_req),
        .req1_pkt_i (ipsum_pkt),
        .gnt0_o     (opsum_gnt),
        .gnt1_o     (ipsum_gnt),
        .glb_req_o  (glb_req),
        .glb_en_o   (glb_en)
    );

    glb_sram u_glb_sram (
        .clk     (clk),
        .en_i    (glb_en),
        .req_i   (glb_req),
        .rdata_o (glb_rdata)
    );

    psum_fifo u_psum_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_i     (fifo_clear_i),
        .push_i      (fifo_push),
        .push_data_i (fifo_push_data),
        .pop_i       (pop_valid_o),
        .pop_data_o  (pop_data_o),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

endmodule

//--- source/opsum_wb_ctrl.sv
`timescale 1ns/1ns

module opsum_wb_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fifo_clear_i,
    input  logic                opsum_valid_i,
    input  psum_pkg::glb_data_t opsum_data_i,
    input  psum_pkg::glb_addr_t opsum_base_i,
    output logic                opsum_ready_o,
    output logic                wr_req_o,
    output psum_pkg::glb_req_t  wr_pkt_o,
    input  logic                wr_gnt_i
);
    import psum_pkg::*;

    logic      hold_q;  // one word waiting for the glb
    glb_data_t data_q;
    glb_addr_t wr_ptr;
    logic      accept;

    assign opsum_ready_o = !hold_q;
    assign accept        = opsum_valid_i && !hold_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            hold_q <= 1'b0;
        else if (accept)
            hold_q <= 1'b1;
        else if (wr_gnt_i)
            hold_q <= 1'b0; // free again next cycle
    end

    always_ff @(posedge clk) begin
        if (accept)
            data_q <= opsum_data_i;
    end

    // pointer moves once the word is written, so the request holds still
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wr_ptr <= '0;
        else if (fifo_clear_i)
            wr_ptr <= '0;
        else if (wr_gnt_i)
            wr_ptr <= wr_ptr + 16'd4;
    end

    assign wr_req_o       = hold_q;
    assign wr_pkt_o.we    = 1'b1;
    assign wr_pkt_o.addr  = opsum_base_i + wr_ptr;
    assign wr_pkt_o.wdata = data_q;

endmodule

//--- source/ipsum_fifo_ctrl.sv
`timescale 1ns/1ns
`include "psum_cfg.svh"

module ipsum_fifo_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                glb_busy_i,     // writeback owns the glb
    input  logic                fifo_clear_i,
    input  logic                need_pop_i,     // task start pulse
    input  psum_pkg::pop_num_t  pop_num_i,
    input  logic                mask_i,
    input  logic                permit_push_i,  // read grant
    input  logic                fifo_full_i,
    input  logic                fifo_empty_i,
    input  psum_pkg::glb_addr_t base_addr_i,
    input  psum_pkg::glb_data_t glb_rdata_i,
    output logic                fifo_push_o,
    output psum_pkg::psum_t     fifo_push_data_o,
    output logic                fifo_pop_o,
    output logic                read_req_o,
    output psum_pkg::glb_addr_t read_addr_o,
    output logic                is_pop_state_o,
    input  logic                pe_array_move_i,
    output logic                done_o
);
    import psum_pkg::*;

    localparam int unsigned BURST_W = $clog2(`PSUM_REFILL_BURST + 1);

    ipsum_state_t       state_q;
    ipsum_state_t       state_d;
    pop_num_t           pop_num_q;
    pop_num_t           pop_cnt;
    glb_addr_t          read_ptr;
    logic [BURST_W-1:0] req_cnt;
    logic [1:0]         load_sel_q;
    logic               last_pop;
    logic               round_done;

    assign last_pop   = fifo_pop_o && ((pop_cnt + 1'b1) == pop_num_q);
    // all reads of this round granted and the last one already pushed
    assign round_done = (req_cnt == BURST_W'(`PSUM_REFILL_BURST)) && !fifo_push_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= IDLE;
        else if (fifo_clear_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (need_pop_i)
                    state_d = fifo_empty_i ? PUSH : CAN_POP;
            end
            CAN_POP: begin
                if (last_pop)
                    state_d = IDLE;
                else if (fifo_empty_i)
                    state_d = PUSH; // refill
            end
            PUSH: begin
                if (fifo_full_i || round_done)
                    state_d = glb_busy_i ? WAIT : CAN_POP;
            end
            WAIT: begin
                if (!glb_busy_i)
                    state_d = CAN_POP;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pop_num_q <= '0;
        else if (need_pop_i)
            pop_num_q <= pop_num_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pop_cnt <= '0;
        else if (fifo_clear_i || state_q == IDLE)
            pop_cnt <= '0;
        else if (fifo_pop_o)
            pop_cnt <= pop_cnt + 1'b1;
    end

    // half word granularity, two bytes per read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            read_ptr <= '0;
        else if (fifo_clear_i)
            read_ptr <= '0;
        else if (permit_push_i)
            read_ptr <= read_ptr + 16'd2;
    end

    assign read_addr_o = base_addr_i + read_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            req_cnt <= '0;
        else if (fifo_clear_i || state_q == IDLE || state_q == CAN_POP)
            req_cnt <= '0; // new round
        else if (permit_push_i)
            req_cnt <= req_cnt + 1'b1;
    end

    assign read_req_o = (state_q == PUSH) && !fifo_full_i
                        && (req_cnt < BURST_W'(`PSUM_REFILL_BURST));

    // push lines up with the sram read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo_push_o <= 1'b0;
            load_sel_q  <= `LOAD_LO_HALF;
        end else begin
            fifo_push_o <= permit_push_i && !fifo_full_i && !fifo_clear_i;
            load_sel_q  <= read_addr_o[1] ? `LOAD_HI_HALF : `LOAD_LO_HALF;
        end
    end

    always_comb begin
        case (load_sel_q)
            `LOAD_LO_HALF: fifo_push_data_o = {16'd0, glb_rdata_i[15:0]};
            `LOAD_HI_HALF: fifo_push_data_o = {16'd0, glb_rdata_i[31:16]};
            default:       fifo_push_data_o = '0;
        endcase
    end

    assign fifo_pop_o = (state_q == CAN_POP) && !fifo_empty_i && pe_array_move_i && mask_i;

    assign done_o         = (state_q == IDLE);
    assign is_pop_state_o = (state_q == CAN_POP);

endmodule

//--- source/glb_sram.sv
`timescale 1ns/1ns
`include "psum_cfg.svh"

module glb_sram (
    input  logic                clk,
    input  logic                en_i,
    input  psum_pkg::glb_req_t  req_i,
    output psum_pkg::glb_data_t rdata_o
);
    import psum_pkg::*;

    localparam int unsigned IDX_W = $clog2(`GLB_WORDS);

    glb_data_t        mem [`GLB_WORDS];
    logic [IDX_W-1:0] word_idx;

    // byte address to word index
    assign word_idx = req_i.addr[IDX_W+1:2];

    // single port, write has priority by construction
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (req_i.we)
                mem[word_idx] <= req_i.wdata;
            else
                rdata_o <= mem[word_idx]; // valid the cycle after the read grant
        end
    end

endmodule

//--- source/glb_arbiter.sv
`timescale 1ns/1ns

module glb_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req0_i,
    input  psum_pkg::glb_req_t req0_i_pkt,
    input  logic               req1_i,
    input  psum_pkg::glb_req_t req1_pkt_i,
    output logic               gnt0_o,
    output logic               gnt1_o,
    output psum_pkg::glb_req_t glb_req_o,
    output logic               glb_en_o
);

    // set when requester 1 won the most recent grant
    logic last1_q;

    // on a tie the requester that did not win last goes first
    assign gnt0_o = req0_i && (!req1_i || last1_q);
    assign gnt1_o = req1_i && (!req0_i || !last1_q);

    assign glb_en_o  = gnt0_o || gnt1_o;
    assign glb_req_o = gnt0_o ? req0_i_pkt : req1_pkt_i; // only meaningful with glb_en_o

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            last1_q <= 1'b1; // first tie goes to writeback
        else if (gnt0_o)
            last1_q <= 1'b0;
        else if (gnt1_o)
            last1_q <= 1'b1;
    end

endmodule

//--- source/psum_fifo.sv
`timescale 1ns/1ns
`include "psum_cfg.svh"

module psum_fifo (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clear_i,
    input  logic            push_i,
    input  psum_pkg::psum_t push_data_i,
    input  logic            pop_i,
    output psum_pkg::psum_t pop_data_o,
    output logic            full_o,
    output logic            empty_o
);
    import psum_pkg::*;

    localparam int unsigned PTR_W = $clog2(`PSUM_FIFO_DEPTH);
    localparam int unsigned CNT_W = $clog2(`PSUM_FIFO_DEPTH + 1);

    psum_t            mem [`PSUM_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count == CNT_W'(`PSUM_FIFO_DEPTH));
    assign empty_o = (count == '0);

    assign do_push = push_i && !full_o;  // dropped when full
    assign do_pop  = pop_i && !empty_o;

    assign pop_data_o = mem[rd_ptr]; // head of queue

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data_i;
    end

endmodule

//--- source/psum_pkg.sv
package psum_pkg;

    // glb byte address
    typedef logic [15:0] glb_addr_t;

    // one glb word
    typedef logic [31:0] glb_data_t;

    // fifo entry, zero-extended half word
    typedef logic [31:0] psum_t;

    // number of pops in one task
    typedef logic [31:0] pop_num_t;

    // request as seen by the glb port
    typedef struct packed {
        logic      we;    // 1 = write
        glb_addr_t addr;  // byte address
        glb_data_t wdata;
    } glb_req_t;

    // input-sum controller task states
    typedef enum logic [1:0] {
        IDLE,
        CAN_POP,
        PUSH,
        WAIT
    } ipsum_state_t;

endpackage

//--- source/psum_cfg.svh
`ifndef PSUM_CFG_SVH
`define PSUM_CFG_SVH

// psum fifo entries
`define PSUM_FIFO_DEPTH 8

// max glb reads in one refill round
`define PSUM_REFILL_BURST 4

// half word select codes for a glb word
`define LOAD_LO_HALF 2'd1 // bits 15:0
`define LOAD_HI_HALF 2'd2 // bits 31:16

// glb depth in 32-bit words
`define GLB_WORDS 256

`endif // PSUM_CFG_SVH
